// File: piano_pkg.sv
`default_nettype none

package piano_pkg;

    //////////////////////////////////////////////////////////////////////
    // Notes and commands
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        REST, DO, RE, MI, FA, SO, LA, SI
    } note_e;                                   // Key i plays note i+1

    typedef logic [1:0] octave_t;               // 0 lowest, 3 highest

    typedef struct packed {
        note_e      note;
        octave_t    octave;
        logic [3:0] dur;                        // Length in ticks
    } tone_cmd_t;

    typedef struct packed {
        note_e      note;
        octave_t    octave;
        logic [3:0] dur;
        logic       last;                       // Final step of the song
    } song_step_t;

    // Half period at octave 0, in clock cycles
    // Octave k uses this value shifted right by k
    function automatic logic [7:0] note_half(input note_e n);
        case (n)
            DO:      return 8'd16;
            RE:      return 8'd14;
            MI:      return 8'd13;
            FA:      return 8'd12;
            SO:      return 8'd11;
            LA:      return 8'd10;
            SI:      return 8'd9;
            default: return 8'd0;               // Rest never toggles
        endcase
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Song table, two songs of up to 16 steps
    //////////////////////////////////////////////////////////////////////

    function automatic song_step_t song_step(input logic song, input logic [3:0] idx);
        case ({song, idx})
            // Song 0, twinkle
            5'h00:   return '{DO,   2'd1, 4'd1, 1'b0};
            5'h01:   return '{DO,   2'd1, 4'd1, 1'b0};
            5'h02:   return '{SO,   2'd1, 4'd1, 1'b0};
            5'h03:   return '{SO,   2'd1, 4'd1, 1'b0};
            5'h04:   return '{LA,   2'd1, 4'd1, 1'b0};
            5'h05:   return '{LA,   2'd1, 4'd1, 1'b0};
            5'h06:   return '{SO,   2'd1, 4'd2, 1'b0};
            5'h07:   return '{REST, 2'd1, 4'd1, 1'b0};  // Breath
            5'h08:   return '{FA,   2'd1, 4'd1, 1'b0};
            5'h09:   return '{FA,   2'd1, 4'd1, 1'b0};
            5'h0A:   return '{MI,   2'd1, 4'd1, 1'b0};
            5'h0B:   return '{MI,   2'd1, 4'd1, 1'b0};
            5'h0C:   return '{RE,   2'd1, 4'd1, 1'b0};
            5'h0D:   return '{RE,   2'd1, 4'd1, 1'b0};
            5'h0E:   return '{DO,   2'd1, 4'd2, 1'b1};
            // Song 1, ode
            5'h10:   return '{MI,   2'd2, 4'd1, 1'b0};
            5'h11:   return '{MI,   2'd2, 4'd1, 1'b0};
            5'h12:   return '{FA,   2'd2, 4'd1, 1'b0};
            5'h13:   return '{SO,   2'd2, 4'd1, 1'b0};
            5'h14:   return '{SO,   2'd2, 4'd1, 1'b0};
            5'h15:   return '{FA,   2'd2, 4'd1, 1'b0};
            5'h16:   return '{MI,   2'd2, 4'd1, 1'b0};
            5'h17:   return '{RE,   2'd2, 4'd1, 1'b0};
            5'h18:   return '{DO,   2'd2, 4'd1, 1'b0};
            5'h19:   return '{DO,   2'd2, 4'd1, 1'b0};
            5'h1A:   return '{RE,   2'd2, 4'd1, 1'b0};
            5'h1B:   return '{MI,   2'd2, 4'd1, 1'b0};
            5'h1C:   return '{MI,   2'd2, 4'd2, 1'b0};
            5'h1D:   return '{RE,   2'd2, 4'd1, 1'b0};
            5'h1E:   return '{RE,   2'd2, 4'd2, 1'b1};
            default: return '{REST, 2'd0, 4'd1, 1'b1};  // Past the end
        endcase
    endfunction

endpackage

`default_nettype wire

// File: panel_pkg.sv
`default_nettype none

package panel_pkg;

    typedef enum logic [1:0] {
        MODE_IDLE, MODE_FREE, MODE_AUTO, MODE_LEARN
    } mode_e;

    typedef struct packed {
        logic [3:0] song;                       // Digit 0
        logic [3:0] step;                       // Digit 1
        logic [3:0] score_tens;                 // Digit 2
        logic [3:0] score_units;                // Digit 3
    } disp_t;

    // Active low, bit order dp g f e d c b a
    function automatic logic [7:0] seg_encode(input logic [3:0] d);
        case (d)
            4'h0:    return 8'hC0;
            4'h1:    return 8'hF9;
            4'h2:    return 8'hA4;
            4'h3:    return 8'hB0;
            4'h4:    return 8'h99;
            4'h5:    return 8'h92;
            4'h6:    return 8'h82;
            4'h7:    return 8'hF8;
            4'h8:    return 8'h80;
            4'h9:    return 8'h90;
            4'hA:    return 8'h88;
            4'hB:    return 8'h83;
            4'hC:    return 8'hC6;
            4'hD:    return 8'hA1;
            4'hE:    return 8'h86;
            default: return 8'h8E;              // F
        endcase
    endfunction

endpackage

`default_nettype wire

// File: input_debounce.sv
`timescale 1ns/1ps
`default_nettype none

module input_debounce #(
    parameter int DEBOUNCE_CYCLES = 16
) (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic song_next,
    input  logic song_prev,
    output logic start_press,
    output logic next_press,
    output logic prev_press
);

    localparam int CW = $clog2(DEBOUNCE_CYCLES + 1);

    // Bit 0 start, bit 1 next, bit 2 prev
    logic [2:0]    sync1;
    logic [2:0]    sync2;
    logic [2:0]    level;                       // Accepted level
    logic [2:0]    press;
    logic [CW-1:0] cnt [3];                     // Cycles differing from level

    always_ff @(posedge clk) begin
        if (rst) begin
            sync1 <= '0;
            sync2 <= '0;
        end else begin
            sync1 <= {song_prev, song_next, start};
            sync2 <= sync1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            level <= '0;
            press <= '0;
            for (int i = 0; i < 3; i++) begin
                cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 3; i++) begin
                press[i] <= 1'b0;
                if (sync2[i] == level[i]) begin
                    cnt[i] <= '0;               // Glitch over, start again
                end else if (cnt[i] == CW'(DEBOUNCE_CYCLES - 1)) begin
                    cnt[i]   <= '0;
                    level[i] <= sync2[i];
                    press[i] <= sync2[i];       // Rising edge only
                end else begin
                    cnt[i] <= cnt[i] + 1'b1;
                end
            end
        end
    end

    assign start_press = press[0];
    assign next_press  = press[1];
    assign prev_press  = press[2];

endmodule

`default_nettype wire

// File: tone_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tone_gen #(
    parameter int TICK_DIV = 64
) (
    input  logic                 clk,
    input  logic                 rst,
    input  piano_pkg::tone_cmd_t tone_cmd,
    input  logic                 tone_valid,
    output logic                 tone_ready,
    output logic                 speaker
);

    import piano_pkg::*;

    localparam int TW = $clog2(TICK_DIV + 1);

    logic          busy;
    logic          take;                        // Transfer this cycle
    logic          is_rest;
    logic [7:0]    half_len;                    // Cycles per speaker level
    logic [7:0]    half_cnt;
    logic [TW-1:0] tick_cnt;
    logic [3:0]    dur_left;                    // Ticks still to play
    logic          tick_end;

    assign tone_ready = ~busy;
    assign take       = tone_valid & tone_ready;
    assign tick_end   = (tick_cnt == TW'(TICK_DIV - 1));

    // Latched command payload
    always_ff @(posedge clk) begin
        if (take) begin
            is_rest  <= (tone_cmd.note == REST);
            half_len <= note_half(tone_cmd.note) >> tone_cmd.octave;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            speaker  <= 1'b0;
            half_cnt <= '0;
            tick_cnt <= '0;
            dur_left <= '0;
        end else if (take) begin
            busy     <= 1'b1;
            speaker  <= (tone_cmd.note != REST); // First level high
            half_cnt <= (note_half(tone_cmd.note) >> tone_cmd.octave) - 8'd1;
            tick_cnt <= '0;
            dur_left <= tone_cmd.dur;
        end else if (busy) begin
            // Duration in ticks of TICK_DIV cycles
            if (tick_end) begin
                tick_cnt <= '0;
                dur_left <= dur_left - 1'b1;
            end else begin
                tick_cnt <= tick_cnt + 1'b1;
            end

            if (tick_end && dur_left <= 4'd1) begin
                busy    <= 1'b0;                // Done, back to silence
                speaker <= 1'b0;
            end else if (half_cnt == 8'd0) begin
                half_cnt <= half_len - 8'd1;
                speaker  <= ~speaker & ~is_rest;
            end else begin
                half_cnt <= half_cnt - 8'd1;
            end
        end
    end

endmodule

`default_nettype wire

// File: seg_scan.sv
`timescale 1ns/1ps
`default_nettype none

module seg_scan #(
    parameter int SCAN_DIV = 8
) (
    input  logic             clk,
    input  logic             rst,
    input  panel_pkg::disp_t disp,
    output logic [7:0]       seg,
    output logic [3:0]       an
);

    import panel_pkg::*;

    localparam int SW = $clog2(SCAN_DIV + 1);

    logic [SW-1:0] div_cnt;
    logic [1:0]    digit;                       // Digit being driven
    logic [3:0]    digit_val;

    always_comb begin
        case (digit)
            2'd0:    digit_val = disp.song;
            2'd1:    digit_val = disp.step;
            2'd2:    digit_val = disp.score_tens;
            default: digit_val = disp.score_units;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            div_cnt <= '0;
            digit   <= 2'd0;
            an      <= 4'b1110;                 // Digit 0 first
        end else begin
            if (div_cnt == SW'(SCAN_DIV - 1)) begin
                div_cnt <= '0;
                digit   <= digit + 2'd1;        // Wraps 3 to 0
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
            an <= ~(4'b0001 << digit);
        end
    end

    // Same cycle as an, so pattern and anode stay paired
    always_ff @(posedge clk) begin
        seg <= seg_encode(digit_val);
    end

endmodule

`default_nettype wire

// File: piano_controller.sv
`timescale 1ns/1ps
`default_nettype none

module piano_controller (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [6:0]           keys,
    input  logic [2:0]           mode,
    input  piano_pkg::octave_t   octave,
    input  logic [1:0]           speed_select,
    input  logic                 start_press,
    input  logic                 next_press,
    input  logic                 prev_press,
    input  logic                 tone_ready,
    output piano_pkg::tone_cmd_t tone_cmd,
    output logic                 tone_valid,
    output logic [6:0]           led,
    output panel_pkg::disp_t     disp
);

    import piano_pkg::*;
    import panel_pkg::*;

    typedef enum logic [1:0] {
        IDLE, ISSUE, WAIT_DONE, WAIT_KEY
    } ctrl_state_e;

    ctrl_state_e state;
    mode_e       mode_q;
    mode_e       mode_dec;
    logic        song;
    logic [3:0]  step;
    logic [3:0]  step_adv;                      // Next index, wraps after last
    logic [3:0]  score_tens;
    logic [3:0]  score_units;
    logic [3:0]  tens_inc;
    logic [3:0]  units_inc;
    logic [6:0]  keys_q;
    logic [6:0]  key_rise;
    logic [7:0]  exp_oh;
    song_step_t  cur;                           // Step at current index
    song_step_t  nxt;
    song_step_t  first;

    // Lowest set key gives the note
    function automatic note_e key_note(input logic [6:0] k);
        note_e n;
        n = REST;
        for (int i = 6; i >= 0; i--) begin
            if (k[i]) begin
                n = note_e'(3'(i + 1));
            end
        end
        return n;
    endfunction

    // Duration times speed+1, saturates at 15 ticks
    function automatic logic [3:0] scale_dur(input logic [3:0] d, input logic [1:0] s);
        logic [5:0] p;
        p = {2'b00, d} * ({4'b0000, s} + 6'd1);
        return (p > 6'd15) ? 4'd15 : p[3:0];
    endfunction

    always_comb begin
        case (mode)                             // One-hot switch
            3'b100:  mode_dec = MODE_FREE;
            3'b010:  mode_dec = MODE_AUTO;
            3'b001:  mode_dec = MODE_LEARN;
            default: mode_dec = MODE_IDLE;
        endcase
    end

    // BCD score, holds at 99
    always_comb begin
        tens_inc  = score_tens;
        units_inc = score_units + 4'd1;
        if (score_units == 4'd9) begin
            if (score_tens == 4'd9) begin
                units_inc = 4'd9;
            end else begin
                tens_inc  = score_tens + 4'd1;
                units_inc = 4'd0;
            end
        end
    end

    assign cur      = song_step(song, step);
    assign nxt      = song_step(song, step + 4'd1);
    assign first    = song_step(song, 4'd0);
    assign step_adv = cur.last ? 4'd0 : step + 4'd1;
    assign key_rise = keys & ~keys_q;
    assign exp_oh   = 8'b1 << cur.note;         // Rest lands on bit 0
    assign disp     = '{song:        {3'b000, song},
                        step:        step,
                        score_tens:  score_tens,
                        score_units: score_units};

    //////////////////////////////////////////////////////////////////////
    // Mode FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= IDLE;
            mode_q      <= MODE_IDLE;
            song        <= 1'b0;
            step        <= '0;
            score_tens  <= '0;
            score_units <= '0;
            keys_q      <= '0;
            tone_valid  <= 1'b0;
            led         <= '0;
        end else begin
            mode_q <= mode_dec;
            keys_q <= keys;
            led    <= (mode_q == MODE_LEARN) ? exp_oh[7:1] : 7'd0;

            case (state)
                IDLE: begin
                    case (mode_q)
                        MODE_FREE: begin
                            if ($onehot(keys)) begin  // Chords play nothing
                                tone_cmd   <= '{key_note(keys), octave, 4'd1};
                                tone_valid <= 1'b1;
                                state      <= ISSUE;
                            end
                        end
                        MODE_AUTO: begin
                            if (start_press) begin
                                step       <= '0;
                                tone_cmd   <= '{first.note, first.octave,
                                                scale_dur(first.dur, speed_select)};
                                tone_valid <= 1'b1;
                                state      <= ISSUE;
                            end
                        end
                        MODE_LEARN: state <= WAIT_KEY;
                        default: ;
                    endcase
                end

                ISSUE: begin
                    if (tone_ready) begin       // Transfer, command held till now
                        tone_valid <= 1'b0;
                        case (mode_q)
                            MODE_AUTO:  state <= WAIT_DONE;
                            MODE_LEARN: state <= WAIT_KEY;
                            default:    state <= IDLE;
                        endcase
                    end
                end

                WAIT_DONE: begin
                    if (mode_q != MODE_AUTO) begin
                        state <= IDLE;
                    end else if (tone_ready) begin
                        if (cur.last) begin
                            step  <= '0;        // Song over
                            state <= IDLE;
                        end else begin
                            step       <= step + 4'd1;
                            tone_cmd   <= '{nxt.note, nxt.octave,
                                            scale_dur(nxt.dur, speed_select)};
                            tone_valid <= 1'b1;
                            state      <= ISSUE;
                        end
                    end
                end

                WAIT_KEY: begin
                    if (mode_q != MODE_LEARN) begin
                        state <= IDLE;
                    end else if (cur.note == REST) begin
                        step <= step_adv;       // Nothing to press on a rest
                    end else if ($onehot(key_rise)) begin
                        tone_cmd   <= '{key_note(key_rise), octave, 4'd1};
                        tone_valid <= 1'b1;
                        state      <= ISSUE;
                        if (key_note(key_rise) == cur.note) begin
                            score_tens  <= tens_inc;
                            score_units <= units_inc;
                            step        <= step_adv;
                        end
                    end
                end

                default: state <= IDLE;
            endcase

            // Song select wins over step updates above
            if (next_press || prev_press) begin
                song        <= ~song;           // Either button flips between the two songs
                step        <= '0;
                score_tens  <= '0;
                score_units <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: mini_piano.sv
`timescale 1ns/1ps
`default_nettype none

module mini_piano #(
    parameter int TICK_DIV        = 64,
    parameter int DEBOUNCE_CYCLES = 16,
    parameter int SCAN_DIV        = 8
) (
    input  logic       clk,
    input  logic       rst,
    input  logic [6:0] keys,                    // One per note, DO to SI
    input  logic [2:0] mode,                    // 100 free, 010 auto, 001 learn
    input  logic [1:0] octave,
    input  logic [1:0] speed_select,
    input  logic       start,
    input  logic       song_next,
    input  logic       song_prev,
    output logic       speaker,
    output logic [6:0] led,
    output logic [7:0] seg,
    output logic [3:0] an
);

    import piano_pkg::*;
    import panel_pkg::*;

    logic      start_press;
    logic      next_press;
    logic      prev_press;
    tone_cmd_t tone_cmd;
    logic      tone_valid;
    logic      tone_ready;
    disp_t     disp;

    input_debounce #(
        .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
    ) debounce_i (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .song_next  (song_next),
        .song_prev  (song_prev),
        .start_press(start_press),
        .next_press (next_press),
        .prev_press (prev_press)
    );

    piano_controller ctrl_i (
        .clk         (clk),
        .rst         (rst),
        .keys        (keys),
        .mode        (mode),
        .octave      (octave),
        .speed_select(speed_select),
        .start_press (start_press),
        .next_press  (next_press),
        .prev_press  (prev_press),
        .tone_ready  (tone_ready),
        .tone_cmd    (tone_cmd),
        .tone_valid  (tone_valid),
        .led         (led),
        .disp        (disp)
    );

    tone_gen #(
        .TICK_DIV(TICK_DIV)
    ) tone_i (
        .clk       (clk),
        .rst       (rst),
        .tone_cmd  (tone_cmd),
        .tone_valid(tone_valid),
        .tone_ready(tone_ready),
        .speaker   (speaker)
    );

    seg_scan #(
        .SCAN_DIV(SCAN_DIV)
    ) scan_i (
        .clk (clk),
        .rst (rst),
        .disp(disp),
        .seg (seg),
        .an  (an)
    );

endmodule

`default_nettype wire

// File: tb_mini_piano.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mini_piano;

    import piano_pkg::*;
    import panel_pkg::*;

    localparam int TICK_DIV        = 64;
    localparam int DEBOUNCE_CYCLES = 16;
    localparam int SCAN_DIV        = 8;

    logic        clk;
    logic        rst;
    logic [6:0]  keys;
    logic [2:0]  mode;
    logic [1:0]  octave;
    logic [1:0]  speed_select;
    logic        start;
    logic        song_next;
    logic        song_prev;
    logic        speaker;
    logic [6:0]  led;
    logic [7:0]  seg;
    logic [3:0]  an;

    int          errors;
    int          tests;
    int          failed_tests;
    int          err_mark;
    logic [31:0] lcg_state;

    mini_piano #(
        .TICK_DIV       (TICK_DIV),
        .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES),
        .SCAN_DIV       (SCAN_DIV)
    ) dut_i (
        .clk(clk), .rst(rst), .keys(keys), .mode(mode), .octave(octave),
        .speed_select(speed_select), .start(start), .song_next(song_next),
        .song_prev(song_prev), .speaker(speaker), .led(led), .seg(seg), .an(an)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;                  // 8 ns period
    end

    // Hard stop in case a wait loop misbehaves
    initial begin
        repeat (60000) @(posedge clk);
        $display("Run stopped at the global cycle limit");
        $display("SOME TESTS FAILED");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // Drive and sample point, just after the rising edge
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else begin
            $display("Check failed: %s", what);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == err_mark) begin
            $display("Test %0d %s: passed", tests, name);
        end else begin
            failed_tests++;
            $display("Test %0d %s: failed with %0d errors", tests, name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    task automatic wait_rise(input int limit, output logic seen);
        seen = 1'b0;
        for (int i = 0; i < limit && !seen; i++) begin
            tick();
            seen = speaker;
        end
    endtask

    // Cycles the speaker stays at lvl, counting the current sample
    task automatic level_len(input logic lvl, input int limit, output int len);
        len = 0;
        while (speaker === lvl && len < limit) begin
            len++;
            tick();
        end
    endtask

    task automatic check_silent(input int cycles, input string what);
        int highs;
        highs = 0;
        repeat (cycles) begin
            tick();
            if (speaker !== 1'b0) highs++;
        end
        check_value({"speaker high cycles ", what}, highs, 0);
    endtask

    // Waits for anode idx, then compares its pattern
    task automatic check_digit(input int idx, input logic [3:0] val, input string name);
        logic found;
        found = 1'b0;
        for (int i = 0; i < 4 * SCAN_DIV + 4 && !found; i++) begin
            tick();
            if (an[idx] == 1'b0) begin
                found = 1'b1;
                check_value(name, seg, seg_encode(val));
            end
        end
        check_true(found, $sformatf("digit %0d was never scanned", idx));
    endtask

    task automatic pulse_button(input int sel, input int hold);
        if (sel == 0) start = 1'b1;
        else song_next = 1'b1;
        repeat (hold) tick();
        start     = 1'b0;
        song_next = 1'b0;
    endtask

    // Press a key, hear its tone, wait for the tone to finish
    task automatic press_key(input int k);
        logic seen;
        int   quiet;
        keys = 7'(1 << k);
        wait_rise(8, seen);
        keys = '0;
        check_true(seen, $sformatf("key %0d gave no tone", k));
        quiet = 0;
        for (int i = 0; i < 4 * TICK_DIV && quiet < 24; i++) begin
            tick();
            quiet = speaker ? 0 : quiet + 1;
        end
        check_true(quiet >= 24, "learn mode tone never ended");
    endtask

    function automatic logic [6:0] led_for(input logic sng, input int s);
        song_step_t st;
        st = song_step(sng, 4'(s));
        return 7'(1 << (int'(st.note) - 1));
    endfunction

    // Next expected learn step, rests are skipped
    function automatic int learn_next(input logic sng, input int s);
        song_step_t st;
        int         n;
        st = song_step(sng, 4'(s));
        n  = st.last ? 0 : s + 1;
        st = song_step(sng, 4'(n));
        if (st.note == REST) n = st.last ? 0 : n + 1;
        return n;
    endfunction

    task automatic play_song(input logic sng, input logic [1:0] spd);
        song_step_t st;
        int         len;
        int         h;
        int         hi;
        int         lo;
        int         t;
        int         last_hi;
        logic       seen;
        logic       done;
        speed_select = spd;
        start        = 1'b1;
        seen         = 1'b0;
        // Start held while the first note is awaited
        for (int i = 0; i < DEBOUNCE_CYCLES + 40 && !seen; i++) begin
            tick();
            seen = speaker;
            if (i == DEBOUNCE_CYCLES + 4) start = 1'b0;
        end
        start = 1'b0;
        done  = 1'b0;
        for (int idx = 0; idx < 16 && !done; idx++) begin
            st   = song_step(sng, 4'(idx));
            len  = int'(st.dur) * (int'(spd) + 1) * TICK_DIV;
            done = st.last;
            if (st.note == REST) begin
                level_len(1'b0, len + 20, lo);
                check_true(lo >= len && lo <= len + 6,
                           $sformatf("rest step %0d silent %0d cycles, expected %0d",
                                     idx, lo, len));
                seen = speaker;
            end else begin
                if (!seen) wait_rise(8, seen);
                check_true(seen, $sformatf("song step %0d never started", idx));
                h = int'(note_half(st.note)) >> st.octave;
                level_len(1'b1, 300, hi);
                level_len(1'b0, 300, lo);
                check_value("speaker high cycles", hi, h);
                check_value("speaker low cycles", lo, h);
                t       = hi + lo;
                last_hi = 0;
                while (t < len) begin
                    if (speaker) last_hi = t;
                    tick();
                    t++;
                end
                check_value("speaker", speaker, 0);   // Step over on time
                check_true(last_hi >= len - 2 * h,
                           $sformatf("song step %0d tone stopped early", idx));
                seen = 1'b0;
            end
        end
        check_silent(2 * TICK_DIV, "after last song step");
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] r;
        int          k;
        int          o;
        int          h;
        int          hi;
        int          lo;
        int          exp_step;
        int          score;
        logic        seen;
        song_step_t  st;
        logic [3:0]  prev_an;
        int          falls [4];
        logic [3:0]  exp_dig [4];

        errors = 0;
        tests = 0;
        failed_tests = 0;
        err_mark = 0;
        lcg_state = 32'd17761;
        rst = 1'b1;
        keys = '0;
        mode = 3'b000;                          // Idle
        octave = '0;
        speed_select = '0;
        start = 1'b0;
        song_next = 1'b0;
        song_prev = 1'b0;
        repeat (8) tick();
        rst = 1'b0;
        tick();

        // 1, state after reset
        check_value("speaker", speaker, 0);
        check_value("led", led, 0);
        check_digit(2, 4'd0, "seg (score tens)");
        check_digit(3, 4'd0, "seg (score units)");
        end_test("reset");

        // 2, free mode pitch and release
        mode = 3'b100;
        repeat (4) tick();
        for (int n = 0; n < 4; n++) begin
            r      = lcg_next();
            k      = int'(r[23:16]) % 7;
            o      = int'(r[29:28]);
            h      = int'(note_half(note_e'(3'(k + 1)))) >> o;
            octave = 2'(o);
            keys   = 7'(1 << k);
            wait_rise(16, seen);
            check_true(seen, $sformatf("free mode key %0d gave no tone", k));
            level_len(1'b1, 300, hi);
            level_len(1'b0, 300, lo);
            check_value("speaker high cycles", hi, h);
            check_value("speaker low cycles", lo, h);
            keys = '0;
            repeat (2 * TICK_DIV) tick();       // Current and queued note drain
            check_silent(TICK_DIV, "after key release");
        end
        end_test("free mode pitch");

        // 3, auto mode at two speeds
        mode = 3'b010;
        repeat (4) tick();
        play_song(1'b0, 2'd0);
        play_song(1'b0, 2'd1);
        end_test("auto mode song");

        // 4, learn mode scoring with one wrong press
        mode     = 3'b001;
        octave   = 2'd0;
        exp_step = 0;
        score    = 0;
        repeat (4) tick();
        for (int n = 0; n < 10; n++) begin
            st = song_step(1'b0, 4'(exp_step));
            check_value("led", led, led_for(1'b0, exp_step));
            if (n == 3) begin
                press_key(int'(st.note) % 7);   // Neighbouring note, wrong
                check_value("led", led, led_for(1'b0, exp_step));
                check_digit(3, 4'(score % 10), "seg (score units)");
            end
            press_key(int'(st.note) - 1);
            score++;
            exp_step = learn_next(1'b0, exp_step);
            check_digit(2, 4'(score / 10), "seg (score tens)");
            check_digit(3, 4'(score % 10), "seg (score units)");
        end
        check_value("led", led, led_for(1'b0, exp_step));
        check_digit(1, 4'(exp_step), "seg (step)");
        end_test("learn mode scoring");

        // 5, glitches ignored, clean song_next accepted
        mode = 3'b010;
        repeat (4) tick();
        pulse_button(0, DEBOUNCE_CYCLES / 2);
        check_silent(DEBOUNCE_CYCLES + TICK_DIV, "after start glitch");
        pulse_button(1, DEBOUNCE_CYCLES / 2);
        repeat (DEBOUNCE_CYCLES + 4) tick();
        check_digit(0, 4'd0, "seg (song)");
        check_digit(2, 4'(score / 10), "seg (score tens)");
        pulse_button(1, DEBOUNCE_CYCLES + 4);
        repeat (DEBOUNCE_CYCLES + 4) tick();
        check_digit(0, 4'd1, "seg (song)");
        check_digit(1, 4'd0, "seg (step)");
        check_digit(2, 4'd0, "seg (score tens)");
        check_digit(3, 4'd0, "seg (score units)");
        end_test("debounce and song select");

        // 6, one full scan round, song 1 and all else zero
        exp_dig = '{4'd1, 4'd0, 4'd0, 4'd0};
        falls   = '{0, 0, 0, 0};
        prev_an = an;
        for (int i = 0; i < 4 * SCAN_DIV; i++) begin
            tick();
            check_value("an low bits", 4 - $countones(an), 1);
            for (int d = 0; d < 4; d++) begin
                if (prev_an[d] && !an[d]) falls[d]++;
                if (!an[d]) check_value($sformatf("seg (digit %0d)", d), seg,
                                        seg_encode(exp_dig[d]));
            end
            prev_an = an;
        end
        for (int d = 0; d < 4; d++) begin
            check_value($sformatf("an[%0d] falling edges", d), falls[d], 1);
        end
        end_test("display scan");

        $display("Tests run %0d, tests failed %0d, errors %0d", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: mini_piano.f
piano_pkg.sv
panel_pkg.sv
input_debounce.sv
tone_gen.sv
seg_scan.sv
piano_controller.sv
mini_piano.sv
tb_mini_piano.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the mini piano testbench with Verilator
verilator --binary --timing --assert -Wno-fatal --top-module tb_mini_piano \
    -f mini_piano.f -o tb_mini_piano > build.log 2>&1 \
    && ./obj_dir/tb_mini_piano > sim.log 2>&1 \
    || { echo "Build or run did not complete, see build.log and sim.log"; exit 1; }
grep -q "SOME TESTS FAILED" sim.log && { echo "Simulation FAILED, see sim.log"; exit 1; }
grep -q "ALL TESTS PASSED" sim.log || { echo "No result found in sim.log"; exit 1; }
echo "Simulation passed"
